/* all.f */
+incdir+design
design/snn_pkg.sv
design/core_ctrl_if.sv
design/in_spike_buf.sv
design/axon_counter.sv
design/core_fsm.sv
design/synapse_array.sv
design/neuron_array.sv
design/snn_core.sv
verification/snn_core_props.sv
verification/snn_core_tb.sv

/* design/axon_counter.sv */
//----------------------------------------------------------
// axon counter
// steps the sweep address over all axons, flags the last
//----------------------------------------------------------
`timescale 1ns/1ps

`include "snn_cfg.svh"

module axon_counter import snn_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_n_i,
	input  logic       clear_i,
	input  logic       step_i,
	output axon_addr_t addr_o,
	output logic       last_o
);

	// highest axon index
	localparam axon_addr_t LAST_ADDR = axon_addr_t'(`SNN_NUM_AXONS - 1);

	assign last_o = (addr_o == LAST_ADDR);

	// clear wins over step
	// step past the last axon wraps to zero, ready for the next sweep
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			addr_o <= '0;
		end else if (clear_i) begin
			addr_o <= '0;
		end else if (step_i) begin
			if (last_o)
				addr_o <= '0;
			else
				addr_o <= addr_o + 1'b1;
		end
	end

endmodule

/* design/core_ctrl_if.sv */
//----------------------------------------------------------
// core control bundle
// strobes from the controller plus the sweep address
//----------------------------------------------------------
`timescale 1ns/1ps

interface core_ctrl_if import snn_pkg::*; ();

	// load recall buffer from the input vector
	logic latch;
	// recall buffer into learn buffer
	logic save;
	// addressed reads, data valid one cycle later
	logic rd_rcl;
	logic rd_lrn;
	// read strobes delayed by one cycle
	logic acc;
	logic lrn_wr;
	// threshold compare and reset
	logic fire;
	// driven by the axon counter
	axon_addr_t addr;

	modport ctrl (
		output latch, save, rd_rcl, rd_lrn, acc, fire, lrn_wr
	);

	modport data (
		input latch, save, rd_rcl, rd_lrn, acc, fire, lrn_wr, addr
	);

endinterface

/* design/core_fsm.sv */
//----------------------------------------------------------
// core controller
// sequences latch, recall sweep, fire and the optional
// learn sweep, and drives the strobes of the data blocks
//----------------------------------------------------------
`timescale 1ns/1ps

module core_fsm import snn_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_n_i,
	input  logic      start_i,
	input  logic      learn_en_i,
	input  logic      last_i,
	output logic      clear_o,
	output logic      step_o,
	core_ctrl_if.ctrl ctrl,
	output logic      busy_o,
	output logic      done_o
);

	// timeline, edge 0 samples start
	//   edges 1..16   recall reads of axons 0..15
	//   edges 2..17   accumulate, the last one in DRAIN
	//   edge 18       fire, done when not learning
	//   edges 19..34  learn reads, write-back one edge later
	//   edge 35       last write-back, done

	core_state_t state_q;
	core_state_t state_d;
	logic        learn_q;
	logic        busy_q;
	logic        done_q;
	logic        acc_q;
	logic        lrn_wr_q;
	logic        start_ok;

	// start is dropped while a run is in flight
	assign start_ok = start_i && !busy_q;

	//------------------------------------------------------
	// next state
	//------------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (start_ok)
					state_d = RECALL;
			end
			RECALL: begin
				if (last_i)
					state_d = DRAIN;
			end
			DRAIN:   state_d = FIRE;
			FIRE:    state_d = learn_q ? LEARN : IDLE;
			LEARN: begin
				if (last_i)
					state_d = LDRAIN;
			end
			LDRAIN:  state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q  <= IDLE;
			learn_q  <= 1'b0;
			busy_q   <= 1'b0;
			done_q   <= 1'b0;
			acc_q    <= 1'b0;
			lrn_wr_q <= 1'b0;
		end else begin
			state_q  <= state_d;
			// read data lands one cycle after the strobe
			acc_q    <= (state_q == RECALL);
			lrn_wr_q <= (state_q == LEARN);
			done_q   <= ((state_q == FIRE) && !learn_q) || (state_q == LDRAIN);
			if (start_ok)
				learn_q <= learn_en_i;
			// busy stays up through the done cycle
			if (start_ok)
				busy_q <= 1'b1;
			else if (done_q)
				busy_q <= 1'b0;
		end
	end

	//------------------------------------------------------
	// strobes
	//------------------------------------------------------
	assign clear_o     = start_ok;
	assign step_o      = (state_q == RECALL) || (state_q == LEARN);
	assign ctrl.latch  = start_ok;
	assign ctrl.rd_rcl = (state_q == RECALL);
	assign ctrl.rd_lrn = (state_q == LEARN);
	assign ctrl.acc    = acc_q;
	assign ctrl.lrn_wr = lrn_wr_q;
	assign ctrl.fire   = (state_q == FIRE);
	// learn snapshot only for learning runs
	assign ctrl.save   = (state_q == FIRE) && learn_q;

	assign busy_o = busy_q;
	assign done_o = done_q;

endmodule

/* design/in_spike_buf.sv */
//----------------------------------------------------------
// input spike buffer
// holds the recall and learn spike vectors of the crossbar
// and returns the addressed bit one cycle after a read
//----------------------------------------------------------
`timescale 1ns/1ps

module in_spike_buf import snn_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_n_i,
	input  spike_vec_t spike_in_i,
	core_ctrl_if.data  ctrl,
	output logic       rcl_spike_o,
	output logic       lrn_spike_o
);

	//------------------------------------------------------
	// buffers
	//------------------------------------------------------
	spike_vec_t rcl_buf_q;
	spike_vec_t lrn_buf_q;

	// recall vector, taken on the start edge
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rcl_buf_q <= '0;
		end else if (ctrl.latch) begin
			rcl_buf_q <= spike_in_i;
		end
	end

	// learn vector is a snapshot of recall
	// taken at fire, so a new latch cannot disturb the learn sweep
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			lrn_buf_q <= '0;
		end else if (ctrl.save) begin
			lrn_buf_q <= rcl_buf_q;
		end
	end

	//------------------------------------------------------
	// addressed bit reads
	//------------------------------------------------------
	// each bit holds between strobes
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rcl_spike_o <= 1'b0;
			lrn_spike_o <= 1'b0;
		end else begin
			if (ctrl.rd_rcl)
				rcl_spike_o <= rcl_buf_q[ctrl.addr];
			if (ctrl.rd_lrn)
				lrn_spike_o <= lrn_buf_q[ctrl.addr];
		end
	end

endmodule

/* design/neuron_array.sv */
//----------------------------------------------------------
// neuron array
// integrate-and-fire potentials, gated accumulation,
// threshold fire with reset to zero
//----------------------------------------------------------
`timescale 1ns/1ps

`include "snn_cfg.svh"

module neuron_array import snn_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_n_i,
	core_ctrl_if.data   ctrl,
	input  logic        rcl_spike_i,
	input  weight_row_t row_i,
	output fire_vec_t   fired_o
);

	potential_t                pot_q   [`SNN_NUM_NEURONS];
	potential_t                pot_sat [`SNN_NUM_NEURONS];
	logic [`SNN_POT_W:0]       sum     [`SNN_NUM_NEURONS];

	//------------------------------------------------------
	// saturating add of the registered row
	//------------------------------------------------------
	// carry bit set means overflow, clamp to all ones
	always_comb begin
		for (int n = 0; n < `SNN_NUM_NEURONS; n++) begin
			sum[n] = {1'b0, pot_q[n]} + (`SNN_POT_W + 1)'(row_i[n]);
			if (sum[n][`SNN_POT_W])
				pot_sat[n] = '1;
			else
				pot_sat[n] = sum[n][`SNN_POT_W-1:0];
		end
	end

	//------------------------------------------------------
	// potentials and fire
	//------------------------------------------------------
	// sub-threshold potentials carry over into the next run
	// fired_o holds until the next fire strobe
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			fired_o <= '0;
			for (int n = 0; n < `SNN_NUM_NEURONS; n++)
				pot_q[n] <= '0;
		end else if (ctrl.fire) begin
			for (int n = 0; n < `SNN_NUM_NEURONS; n++) begin
				fired_o[n] <= (pot_q[n] >= potential_t'(`SNN_THRESHOLD));
				if (pot_q[n] >= potential_t'(`SNN_THRESHOLD))
					pot_q[n] <= '0;
			end
		end else if (ctrl.acc && rcl_spike_i) begin
			// silent axons add nothing
			for (int n = 0; n < `SNN_NUM_NEURONS; n++)
				pot_q[n] <= pot_sat[n];
		end
	end

endmodule

/* design/snn_cfg.svh */
//----------------------------------------------------------
// snn core configuration
// sizes, widths and fire level of the crossbar core
//----------------------------------------------------------
`ifndef SNN_CFG_SVH
`define SNN_CFG_SVH

// crossbar size
`define SNN_NUM_AXONS   16
`define SNN_NUM_NEURONS 4
`define SNN_AXON_W      4

// unsigned, saturating
`define SNN_WEIGHT_W    4
`define SNN_POT_W       8

// potential at which a neuron fires
`define SNN_THRESHOLD   8

`endif

/* design/snn_core.sv */
//----------------------------------------------------------
// neuromorphic crossbar core
// 16 axons onto 4 integrate-and-fire neurons with
// spike-driven weight learning
//----------------------------------------------------------
`timescale 1ns/1ps

module snn_core import snn_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  logic        start_i,
	input  logic        learn_en_i,
	input  spike_vec_t  spike_in_i,
	input  logic        wt_wr_i,
	input  axon_addr_t  wt_addr_i,
	input  weight_row_t wt_data_i,
	output fire_vec_t   spikes_o,
	output logic        busy_o,
	output logic        done_o
);

	// counter handshake
	logic        clear;
	logic        step;
	logic        last;
	// read data path
	logic        rcl_spike;
	logic        lrn_spike;
	weight_row_t row;
	fire_vec_t   fired;

	core_ctrl_if ctrl_if ();

	//------------------------------------------------------
	// control
	//------------------------------------------------------
	core_fsm u_fsm (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.start_i    (start_i),
		.learn_en_i (learn_en_i),
		.last_i     (last),
		.clear_o    (clear),
		.step_o     (step),
		.ctrl       (ctrl_if.ctrl),
		.busy_o     (busy_o),
		.done_o     (done_o)
	);

	// sweep address goes straight onto the bundle
	axon_counter u_cnt (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.clear_i (clear),
		.step_i  (step),
		.addr_o  (ctrl_if.addr),
		.last_o  (last)
	);

	//------------------------------------------------------
	// data path
	//------------------------------------------------------
	in_spike_buf u_spk (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.spike_in_i  (spike_in_i),
		.ctrl        (ctrl_if.data),
		.rcl_spike_o (rcl_spike),
		.lrn_spike_o (lrn_spike)
	);

	synapse_array u_syn (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.wt_wr_i     (wt_wr_i),
		.wt_addr_i   (wt_addr_i),
		.wt_data_i   (wt_data_i),
		.ctrl        (ctrl_if.data),
		.lrn_spike_i (lrn_spike),
		.fired_i     (fired),
		.row_o       (row)
	);

	neuron_array u_neu (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.ctrl        (ctrl_if.data),
		.rcl_spike_i (rcl_spike),
		.row_i       (row),
		.fired_o     (fired)
	);

	assign spikes_o = fired;

endmodule

/* design/snn_pkg.sv */
//----------------------------------------------------------
// snn package
// state and payload types shared by the crossbar core
//----------------------------------------------------------
`include "snn_cfg.svh"

package snn_pkg;

	// controller sequence of one run
	typedef enum logic [2:0] {IDLE, RECALL, DRAIN, FIRE, LEARN, LDRAIN} core_state_t;

	typedef logic [`SNN_AXON_W-1:0] axon_addr_t;

	// one axon's weights, element n goes to neuron n
	typedef logic [`SNN_NUM_NEURONS-1:0][`SNN_WEIGHT_W-1:0] weight_row_t;

	typedef logic [`SNN_POT_W-1:0] potential_t;
	typedef logic [`SNN_NUM_AXONS-1:0] spike_vec_t;
	typedef logic [`SNN_NUM_NEURONS-1:0] fire_vec_t;

endpackage

/* design/synapse_array.sv */
//----------------------------------------------------------
// synapse array
// one weight row per axon, external row writes, registered
// row reads and saturating learning write-back
//----------------------------------------------------------
`timescale 1ns/1ps

`include "snn_cfg.svh"

module synapse_array import snn_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  logic        wt_wr_i,
	input  axon_addr_t  wt_addr_i,
	input  weight_row_t wt_data_i,
	core_ctrl_if.data   ctrl,
	input  logic        lrn_spike_i,
	input  fire_vec_t   fired_i,
	output weight_row_t row_o
);

	weight_row_t wt_q [`SNN_NUM_AXONS];
	weight_row_t row_inc;
	axon_addr_t  addr_q;
	logic        sweep_act;

	// no external writes while a sweep touches the rows
	assign sweep_act = ctrl.rd_rcl | ctrl.rd_lrn | ctrl.acc | ctrl.lrn_wr;

	//------------------------------------------------------
	// row read, address kept for write-back
	//------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (ctrl.rd_rcl || ctrl.rd_lrn) begin
			row_o  <= wt_q[ctrl.addr];
			addr_q <= ctrl.addr;
		end
	end

	// +1 toward each fired neuron, stuck at max
	always_comb begin
		for (int n = 0; n < `SNN_NUM_NEURONS; n++) begin
			if (fired_i[n] && (row_o[n] != '1))
				row_inc[n] = row_o[n] + 1'b1;
			else
				row_inc[n] = row_o[n];
		end
	end

	//------------------------------------------------------
	// weight rows
	//------------------------------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int a = 0; a < `SNN_NUM_AXONS; a++)
				wt_q[a] <= '0;
		end else if (ctrl.lrn_wr) begin
			// only axons that spiked learn
			if (lrn_spike_i)
				wt_q[addr_q] <= row_inc;
		end else if (wt_wr_i && !sweep_act) begin
			wt_q[wt_addr_i] <= wt_data_i;
		end
	end

endmodule

/* verification/snn_core_props.sv */
//----------------------------------------------------------
// snn core properties
// controller and output checks bound onto the core
//----------------------------------------------------------
`timescale 1ns/1ps

module snn_core_props import snn_pkg::*; (
	input logic        clk_i,
	input logic        rst_n_i,
	input logic        start_i,
	input logic        busy_o,
	input logic        done_o,
	input core_state_t state_i,
	input logic [6:0]  strobes_i
);

	// done is a single-cycle pulse
	a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		done_o |=> !done_o) else $error("done_o held longer than one cycle");

	// done only inside a run
	a_done_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		done_o |-> busy_o) else $error("done_o seen without busy_o");

	// a start during a run never restarts the recall sweep
	a_start_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(start_i && busy_o && state_i != RECALL) |=> state_i != RECALL)
		else $error("start_i during busy_o restarted the sweep");

	// strobes idle on the first edge out of reset
	a_rst_strobes: assert property (@(posedge clk_i)
		$rose(rst_n_i) |-> strobes_i == '0) else $error("strobe active after reset");

endmodule

bind snn_core snn_core_props u_props (
	.clk_i     (clk_i),
	.rst_n_i   (rst_n_i),
	.start_i   (start_i),
	.busy_o    (busy_o),
	.done_o    (done_o),
	.state_i   (u_fsm.state_q),
	.strobes_i ({ctrl_if.latch, ctrl_if.save, ctrl_if.rd_rcl, ctrl_if.rd_lrn,
		ctrl_if.acc, ctrl_if.fire, ctrl_if.lrn_wr})
);

/* verification/snn_core_tb.sv */
//----------------------------------------------------------
// snn core testbench
// directed and random runs against a reference model
//----------------------------------------------------------
`timescale 1ns/1ps

`include "snn_cfg.svh"

module snn_core_tb import snn_pkg::*; ();

	// edges after the start edge until done is seen
	localparam int RECALL_EDGES = 18;
	localparam int LEARN_EDGES  = 35;
	// 30 random runs with full weight loads dominate, about 2500 cycles
	localparam int MAX_CYCLES   = 6000;

	logic        clk_i;
	logic        rst_n_i;
	logic        start_i;
	logic        learn_en_i;
	spike_vec_t  spike_in_i;
	logic        wt_wr_i;
	axon_addr_t  wt_addr_i;
	weight_row_t wt_data_i;
	fire_vec_t   spikes_o;
	logic        busy_o;
	logic        done_o;

	// reference model
	int          pot_m [`SNN_NUM_NEURONS];
	weight_row_t wt_m  [`SNN_NUM_AXONS];
	fire_vec_t   fired_m;

	int errors = 0;
	int checks = 0;
	int cycles = 0;

	snn_core dut_i (.*);

	initial clk_i = 1'b0;
	always #20 clk_i = ~clk_i;

	// watchdog
	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic check_val(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got 0x%0h exp 0x%0h", name, got, exp);
		end
	endtask

	//------------------------------------------------------
	// reference model
	//------------------------------------------------------
	task automatic model_run(input spike_vec_t spk, input logic learn);
		// integrate, saturating at 255
		for (int a = 0; a < `SNN_NUM_AXONS; a++)
			if (spk[a])
				for (int n = 0; n < `SNN_NUM_NEURONS; n++) begin
					pot_m[n] = pot_m[n] + wt_m[a][n];
					if (pot_m[n] > 255)
						pot_m[n] = 255;
				end
		for (int n = 0; n < `SNN_NUM_NEURONS; n++) begin
			fired_m[n] = (pot_m[n] >= `SNN_THRESHOLD);
			if (fired_m[n])
				pot_m[n] = 0;
		end
		// spiking axon toward fired neuron gains one, max 15
		if (learn)
			for (int a = 0; a < `SNN_NUM_AXONS; a++)
				if (spk[a])
					for (int n = 0; n < `SNN_NUM_NEURONS; n++)
						if (fired_m[n] && wt_m[a][n] != 4'hf)
							wt_m[a][n] = wt_m[a][n] + 1'b1;
	endtask

	//------------------------------------------------------
	// bus actions
	//------------------------------------------------------
	task automatic write_row(input int a, input weight_row_t row);
		@(negedge clk_i);
		wt_wr_i   = 1'b1;
		wt_addr_i = axon_addr_t'(a);
		wt_data_i = row;
		@(negedge clk_i);
		wt_wr_i = 1'b0;
		wt_m[a] = row;
	endtask

	// ign_at is the edge count at which a stray start is driven, -1 for none
	task automatic do_run(input spike_vec_t spk, input logic learn, input int ign_at);
		int edges;
		int exp_edges;
		edges     = 0;
		exp_edges = learn ? LEARN_EDGES : RECALL_EDGES;
		@(negedge clk_i);
		start_i    = 1'b1;
		learn_en_i = learn;
		spike_in_i = spk;
		@(negedge clk_i);
		check_val("busy_o", busy_o, 1);
		while (done_o !== 1'b1 && edges < 2 * LEARN_EDGES) begin
			start_i    = (edges == ign_at);
			spike_in_i = ~spk;
			learn_en_i = ~learn;
			@(negedge clk_i);
			edges++;
		end
		start_i    = 1'b0;
		learn_en_i = 1'b0;
		if (done_o !== 1'b1) begin
			errors++;
			$display("done_o never rose within %0d cycles of start", edges);
		end else begin
			model_run(spk, learn);
			check_val("done latency", edges, exp_edges);
			check_val("spikes_o", spikes_o, fired_m);
			check_val("busy_o", busy_o, 1);
			// stray start in the done cycle, busy must still drop
			if (ign_at == edges) begin
				start_i = 1'b1;
				@(negedge clk_i);
				start_i = 1'b0;
				check_val("busy_o", busy_o, 0);
			end
		end
	endtask

	task automatic check_weights();
		for (int a = 0; a < `SNN_NUM_AXONS; a++)
			check_val($sformatf("wt_q[%0d]", a), dut_i.u_syn.wt_q[a], wt_m[a]);
	endtask

	// every neuron fires once, all potentials back to zero
	task automatic flush_pots();
		write_row(0, '1);
		do_run(16'h0001, 1'b0, -1);
	endtask

	//------------------------------------------------------
	// tests
	//------------------------------------------------------
	task automatic test_reset();
		check_val("spikes_o", spikes_o, 0);
		check_val("busy_o", busy_o, 0);
		check_val("done_o", done_o, 0);
		do_run(spike_vec_t'($urandom), 1'b0, -1);
		check_val("spikes_o", spikes_o, 0);
	endtask

	task automatic test_recall();
		for (int a = 0; a < `SNN_NUM_AXONS; a++)
			write_row(a, {4'(a), 4'(15 - a), 4'(a % 3), 4'(a >> 1)});
		do_run(16'ha5c3, 1'b0, -1);
		do_run(16'h0ff0, 1'b0, -1);
	endtask

	// n0 climbs by 3, n1 by 2, each restarts after firing
	task automatic test_carry();
		fire_vec_t exp_seq [5] = '{4'h0, 4'h0, 4'h1, 4'h2, 4'h0};
		flush_pots();
		write_row(0, 16'h0023);
		for (int r = 0; r < 5; r++) begin
			do_run(16'h0001, 1'b0, -1);
			check_val("spikes_o seq", spikes_o, exp_seq[r]);
		end
	endtask

	task automatic test_learn();
		flush_pots();
		write_row(0, 16'hfe19);
		write_row(1, 16'h0020);
		do_run(16'h0003, 1'b1, -1);
		check_weights();
		// n2 and n3 pinned at 15
		do_run(16'h0003, 1'b1, -1);
		check_weights();
		check_val("wt_q[0] sat", dut_i.u_syn.wt_q[0], 16'hff1b);
		do_run(16'h0003, 1'b0, -1);
	endtask

	task automatic test_random();
		logic learn;
		for (int r = 0; r < 30; r++) begin
			for (int a = 0; a < `SNN_NUM_AXONS; a++)
				write_row(a, weight_row_t'($urandom));
			learn = $urandom % 2;
			do_run(spike_vec_t'($urandom), learn, -1);
			if (learn)
				check_weights();
		end
	endtask

	// stray starts mid recall, mid learn and in the done cycle
	task automatic test_ignored_start();
		do_run(16'h3c3c, 1'b0, 5);
		do_run(16'h0f0f, 1'b1, 25);
		check_weights();
		do_run(16'hffff, 1'b0, RECALL_EDGES);
	endtask

	initial begin
		void'($urandom(12));
		rst_n_i    = 1'b0;
		start_i    = 1'b0;
		learn_en_i = 1'b0;
		spike_in_i = '0;
		wt_wr_i    = 1'b0;
		wt_addr_i  = '0;
		wt_data_i  = '0;
		fired_m    = '0;
		for (int n = 0; n < `SNN_NUM_NEURONS; n++)
			pot_m[n] = 0;
		for (int a = 0; a < `SNN_NUM_AXONS; a++)
			wt_m[a] = '0;
		repeat (5) @(posedge clk_i);
		@(negedge clk_i);
		rst_n_i = 1'b1;

		test_reset();
		test_recall();
		test_carry();
		test_learn();
		test_random();
		test_ignored_start();

		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
